// ==== verif/mem_stimulus.txt ====
# I/D addr: cache miss, B/P value: register write, S addr: load snoop, W n: idle
# E addr src data: expected memory request (src 0 icache, 1 dcache, 2 prefetch)
W 2
I 00000300
D 00000400
E 00000300 0 3333333333333333
E 00000400 1 4444444444444444
W 20
S 00000000
W 10
B 0000000000001000
P 5a00000001040002
S 00002000
W 10
E 00001020 2 a0a0a0a0a0a0a0a1
E 00001040 2 a0a0a0a0a0a0a0a2
E 00001060 2 a0a0a0a0a0a0a0a3
E 00001080 2 a0a0a0a0a0a0a0a4
S 00001000
W 100
P 000000000103ffff
E 00001070 2 b0b0b0b0b0b0b0b1
E 00001060 2 b0b0b0b0b0b0b0b2
E 00001050 2 b0b0b0b0b0b0b0b3
S 00001080

// ==== compile.f ====
hdl/cache_subsys_pkg.sv
hdl/stride_prefetcher.sv
hdl/miss_arbiter.sv
hdl/refill_router.sv
hdl/cache_mem_subsystem.sv
verif/tb_cache_mem_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := tb_cache_mem_subsystem
RTL_TOP   := cache_mem_subsystem
FILELIST  := compile.f
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build: $(OBJDIR)/V$(TOP)

$(OBJDIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== verif/tb_cache_mem_subsystem.sv ====
`timescale 1ns/100ps

module tb_cache_mem_subsystem;

  localparam int unsigned MaxInflight   = 2;
  localparam int unsigned TimeoutCycles = 2000;

  typedef struct packed {
    logic [cache_subsys_pkg::ADDR_WIDTH-1:0] addr;
    cache_subsys_pkg::mem_src_e              src;
    logic [cache_subsys_pkg::DATA_WIDTH-1:0] data;
  } exp_req_t;

  logic                        clk_i = 1'b0;
  logic                        rst_ni;
  logic                        icache_req_valid_i = 1'b0;
  logic                        icache_req_ready_o;
  cache_subsys_pkg::rd_req_t   icache_req_i = '0;
  logic                        dcache_req_valid_i = 1'b0;
  logic                        dcache_req_ready_o;
  cache_subsys_pkg::rd_req_t   dcache_req_i = '0;
  logic                        snoop_valid_i;
  cache_subsys_pkg::snoop_t    snoop_i;
  logic                        mem_req_valid_o;
  logic                        mem_req_ready_i = 1'b0;
  cache_subsys_pkg::mem_req_t  mem_req_o;
  logic                        mem_rsp_valid_i = 1'b0;
  logic                        mem_rsp_ready_o;
  cache_subsys_pkg::mem_rsp_t  mem_rsp_i = '0;
  logic                        icache_rsp_valid_o;
  cache_subsys_pkg::refill_t   icache_rsp_o;
  logic                        dcache_rsp_valid_o;
  cache_subsys_pkg::refill_t   dcache_rsp_o;
  logic                        pf_base_set_i;
  logic [63:0]                 pf_base_i;
  logic [63:0]                 pf_base_o;
  logic                        pf_param_set_i;
  cache_subsys_pkg::pf_param_u pf_param_i;
  cache_subsys_pkg::pf_param_u pf_param_o;
  logic [63:0]                 pf_status_o;

  logic [31:0]                icache_q[$];
  logic [31:0]                dcache_q[$];
  exp_req_t                   exp_q[$];
  cache_subsys_pkg::mem_rsp_t pending_q[$];
  int                         seed = 32;
  int                         pf_outstanding = 0;
  longint unsigned            pf_rsp_count = 0;

  cache_mem_subsystem #(
    .MaxInflight(MaxInflight)
  ) cache_mem_subsystem_i (.*);

  always #10 clk_i = ~clk_i;

  task automatic stop_failed();
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_failed();
    end
  endtask

  // One request driver per cache fed from its command queue
  always @(posedge clk_i) begin
    if (!icache_req_valid_i || icache_req_ready_o) begin
      if (icache_q.size() != 0) begin
        icache_req_valid_i <= 1'b1;
        icache_req_i.addr  <= icache_q.pop_front();
      end else begin
        icache_req_valid_i <= 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    if (!dcache_req_valid_i || dcache_req_ready_o) begin
      if (dcache_q.size() != 0) begin
        dcache_req_valid_i <= 1'b1;
        dcache_req_i.addr  <= dcache_q.pop_front();
      end else begin
        dcache_req_valid_i <= 1'b0;
      end
    end
  end

  // Memory model with random ready and randomly delayed in-order responses
  always @(posedge clk_i) begin
    logic [31:0]                rnd;
    exp_req_t                   item;
    cache_subsys_pkg::mem_rsp_t rsp;
    if (mem_rsp_valid_i) begin
      check("mem_rsp_ready_o", mem_rsp_ready_o, 1'b1);
      check("icache_rsp_valid_o", icache_rsp_valid_o,
            mem_rsp_i.src == cache_subsys_pkg::SRC_ICACHE);
      check("dcache_rsp_valid_o", dcache_rsp_valid_o,
            mem_rsp_i.src == cache_subsys_pkg::SRC_DCACHE);
      if (mem_rsp_i.src == cache_subsys_pkg::SRC_ICACHE) begin
        check("icache_rsp_o.data", icache_rsp_o.data, mem_rsp_i.data);
      end
      if (mem_rsp_i.src == cache_subsys_pkg::SRC_DCACHE) begin
        check("dcache_rsp_o.data", dcache_rsp_o.data, mem_rsp_i.data);
      end
    end
    if (mem_req_valid_o && mem_req_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("Memory request to %h arrived with none expected", mem_req_o.addr);
        stop_failed();
      end else begin
        item = exp_q.pop_front();
        check("mem_req_o.addr", mem_req_o.addr, item.addr);
        check("mem_req_o.src", mem_req_o.src, item.src);
        pending_q.push_back({item.data, item.src});
        if (item.src == cache_subsys_pkg::SRC_PREFETCH) begin
          pf_outstanding++;
          check("prefetch in flight within limit", pf_outstanding <= MaxInflight, 1'b1);
        end
      end
    end
    rnd = $random(seed);
    mem_req_ready_i <= rnd[0];
    if (pending_q.size() != 0 && rnd[5:4] == 2'b00) begin
      rsp = pending_q.pop_front();
      mem_rsp_valid_i <= 1'b1;
      mem_rsp_i       <= rsp;
      if (rsp.src == cache_subsys_pkg::SRC_PREFETCH) begin
        pf_outstanding--;
        pf_rsp_count++;
      end
    end else begin
      mem_rsp_valid_i <= 1'b0;
    end
  end

  task automatic write_base(input logic [63:0] value);
    @(posedge clk_i);
    pf_base_set_i <= 1'b1;
    pf_base_i     <= value;
    @(posedge clk_i);
    pf_base_set_i <= 1'b0;
    @(negedge clk_i);
    check("pf_base_o", pf_base_o, value);
  endtask

  task automatic write_param(input logic [63:0] value);
    @(posedge clk_i);
    pf_param_set_i <= 1'b1;
    pf_param_i.raw <= value;
    @(posedge clk_i);
    pf_param_set_i <= 1'b0;
    @(negedge clk_i);
    check("pf_param_o", pf_param_o.raw, value);
  endtask

  task automatic pulse_snoop(input logic [31:0] addr);
    @(posedge clk_i);
    snoop_valid_i <= 1'b1;
    snoop_i.addr  <= addr;
    @(posedge clk_i);
    snoop_valid_i <= 1'b0;
    @(negedge clk_i);
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  function automatic bit traffic_done();
    return exp_q.size() == 0 && pending_q.size() == 0 && !mem_rsp_valid_i
           && icache_q.size() == 0 && dcache_q.size() == 0
           && !icache_req_valid_i && !dcache_req_valid_i;
  endfunction

  initial begin
    int             fd;
    int             code;
    int             cycles;
    int             src_val;
    logic [7:0]     cmd;
    logic [31:0]    addr;
    logic [63:0]    value;
    logic [63:0]    exp_base;
    logic [1023:0]  skip_line;
    exp_req_t       item;
    int             waited;
    rst_ni         = 1'b0;
    snoop_valid_i  = 1'b0;
    snoop_i        = '0;
    pf_base_set_i  = 1'b0;
    pf_base_i      = '0;
    pf_param_set_i = 1'b0;
    pf_param_i     = '0;
    exp_base       = '0;
    fd = $fopen("verif/mem_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file verif/mem_stimulus.txt");
      stop_failed();
    end
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": code = $fgets(skip_line, fd);
        "I": begin
          code = $fscanf(fd, "%h", addr);
          icache_q.push_back(addr);
        end
        "D": begin
          code = $fscanf(fd, "%h", addr);
          dcache_q.push_back(addr);
        end
        "B": begin
          code = $fscanf(fd, "%h", value);
          exp_base = value;
          write_base(value);
        end
        "P": begin
          code = $fscanf(fd, "%h", value);
          write_param(value);
        end
        "S": begin
          code = $fscanf(fd, "%h", addr);
          pulse_snoop(addr);
        end
        "E": begin
          code = $fscanf(fd, "%h %d %h", addr, src_val, value);
          item.addr = addr;
          item.src  = cache_subsys_pkg::mem_src_e'(src_val);
          item.data = value;
          // A finished burst leaves the base at its last prefetch address
          if (item.src == cache_subsys_pkg::SRC_PREFETCH) begin
            exp_base = {32'd0, addr};
          end
          exp_q.push_back(item);
        end
        "W": begin
          code = $fscanf(fd, "%d", cycles);
          idle(cycles);
        end
        default: begin
          $display("Unknown command '%c' in the stimulus file", cmd);
          stop_failed();
        end
      endcase
    end
    $fclose(fd);
    waited = 0;
    while (!traffic_done() && waited < TimeoutCycles) begin
      @(negedge clk_i);
      waited++;
    end
    if (!traffic_done()) begin
      $display("Timed out waiting for memory traffic to finish, %0d requests still expected",
               exp_q.size());
      stop_failed();
    end else begin
      // Late or stray requests still hit the model here
      idle(20);
      check("pf_status_o", pf_status_o, pf_rsp_count);
      check("pf_base_o", pf_base_o, exp_base);
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// ==== hdl/cache_mem_subsystem.sv ====
`timescale 1ns/100ps

module cache_mem_subsystem #(
  parameter int unsigned MaxInflight = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        icache_req_valid_i,
  output logic                        icache_req_ready_o,
  input  cache_subsys_pkg::rd_req_t   icache_req_i,
  input  logic                        dcache_req_valid_i,
  output logic                        dcache_req_ready_o,
  input  cache_subsys_pkg::rd_req_t   dcache_req_i,
  input  logic                        snoop_valid_i,
  input  cache_subsys_pkg::snoop_t    snoop_i,
  output logic                        mem_req_valid_o,
  input  logic                        mem_req_ready_i,
  output cache_subsys_pkg::mem_req_t  mem_req_o,
  input  logic                        mem_rsp_valid_i,
  output logic                        mem_rsp_ready_o,
  input  cache_subsys_pkg::mem_rsp_t  mem_rsp_i,
  output logic                        icache_rsp_valid_o,
  output cache_subsys_pkg::refill_t   icache_rsp_o,
  output logic                        dcache_rsp_valid_o,
  output cache_subsys_pkg::refill_t   dcache_rsp_o,
  input  logic                        pf_base_set_i,
  input  logic [63:0]                 pf_base_i,
  output logic [63:0]                 pf_base_o,
  input  logic                        pf_param_set_i,
  input  cache_subsys_pkg::pf_param_u pf_param_i,
  output cache_subsys_pkg::pf_param_u pf_param_o,
  output logic [63:0]                 pf_status_o
);

  logic                      pf_req_valid;
  logic                      pf_req_ready;
  cache_subsys_pkg::rd_req_t pf_req;
  logic                      pf_done;

  stride_prefetcher #(
    .MaxInflight(MaxInflight)
  ) i_stride_prefetcher (
    .clk_i,
    .rst_ni,
    .pf_base_set_i,
    .pf_base_i,
    .pf_base_o,
    .pf_param_set_i,
    .pf_param_i,
    .pf_param_o,
    .pf_status_o,
    .snoop_valid_i,
    .snoop_i,
    .pf_req_valid_o(pf_req_valid),
    .pf_req_ready_i(pf_req_ready),
    .pf_req_o      (pf_req),
    .pf_done_i     (pf_done)
  );

  miss_arbiter i_miss_arbiter (
    .clk_i,
    .rst_ni,
    .icache_req_valid_i,
    .icache_req_ready_o,
    .icache_req_i,
    .dcache_req_valid_i,
    .dcache_req_ready_o,
    .dcache_req_i,
    .pf_req_valid_i(pf_req_valid),
    .pf_req_ready_o(pf_req_ready),
    .pf_req_i      (pf_req),
    .mem_req_valid_o,
    .mem_req_ready_i,
    .mem_req_o
  );

  refill_router i_refill_router (
    .clk_i,
    .rst_ni,
    .mem_rsp_valid_i,
    .mem_rsp_ready_o,
    .mem_rsp_i,
    .icache_rsp_valid_o,
    .icache_rsp_o,
    .dcache_rsp_valid_o,
    .dcache_rsp_o,
    .pf_done_o(pf_done)
  );

endmodule

// ==== hdl/refill_router.sv ====
`timescale 1ns/100ps

module refill_router (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       mem_rsp_valid_i,
  output logic                       mem_rsp_ready_o,
  input  cache_subsys_pkg::mem_rsp_t mem_rsp_i,
  output logic                       icache_rsp_valid_o,
  output cache_subsys_pkg::refill_t  icache_rsp_o,
  output logic                       dcache_rsp_valid_o,
  output cache_subsys_pkg::refill_t  dcache_rsp_o,
  output logic                       pf_done_o
);

  logic to_icache;
  logic to_dcache;
  logic to_pf;

  // Caches never stall a refill
  assign mem_rsp_ready_o = 1'b1;

  assign to_icache = (mem_rsp_i.src == cache_subsys_pkg::SRC_ICACHE);
  assign to_dcache = (mem_rsp_i.src == cache_subsys_pkg::SRC_DCACHE);
  assign to_pf     = (mem_rsp_i.src == cache_subsys_pkg::SRC_PREFETCH);

  assign icache_rsp_valid_o = mem_rsp_valid_i && to_icache;
  assign dcache_rsp_valid_o = mem_rsp_valid_i && to_dcache;

  assign icache_rsp_o.data = mem_rsp_i.data;
  assign dcache_rsp_o.data = mem_rsp_i.data;

  // Prefetched lines only retire a throttle slot
  assign pf_done_o = mem_rsp_valid_i && to_pf;

  // Tag must be one the arbiter could have stamped
  a_rsp_src_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_rsp_valid_i |-> !$isunknown(mem_rsp_i.src) && (to_icache || to_dcache || to_pf)
  );

endmodule

// ==== hdl/miss_arbiter.sv ====
`timescale 1ns/100ps

module miss_arbiter (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       icache_req_valid_i,
  output logic                       icache_req_ready_o,
  input  cache_subsys_pkg::rd_req_t  icache_req_i,
  input  logic                       dcache_req_valid_i,
  output logic                       dcache_req_ready_o,
  input  cache_subsys_pkg::rd_req_t  dcache_req_i,
  input  logic                       pf_req_valid_i,
  output logic                       pf_req_ready_o,
  input  cache_subsys_pkg::rd_req_t  pf_req_i,
  output logic                       mem_req_valid_o,
  input  logic                       mem_req_ready_i,
  output cache_subsys_pkg::mem_req_t mem_req_o
);

  logic                       out_valid_q;
  cache_subsys_pkg::mem_req_t out_q;
  cache_subsys_pkg::mem_req_t sel;
  logic                       can_load;
  logic                       any_valid;

  // Output register is free or empties this cycle
  assign can_load  = !out_valid_q || mem_req_ready_i;
  assign any_valid = icache_req_valid_i || dcache_req_valid_i || pf_req_valid_i;

  // Fixed priority: icache, dcache, prefetch
  assign icache_req_ready_o = can_load;
  assign dcache_req_ready_o = can_load && !icache_req_valid_i;
  assign pf_req_ready_o     = can_load && !icache_req_valid_i && !dcache_req_valid_i;

  always_comb begin
    if (icache_req_valid_i) begin
      sel.addr = icache_req_i.addr;
      sel.src  = cache_subsys_pkg::SRC_ICACHE;
    end else if (dcache_req_valid_i) begin
      sel.addr = dcache_req_i.addr;
      sel.src  = cache_subsys_pkg::SRC_DCACHE;
    end else begin
      sel.addr = pf_req_i.addr;
      sel.src  = cache_subsys_pkg::SRC_PREFETCH;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (can_load) begin
      out_valid_q <= any_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (can_load && any_valid) begin
      out_q <= sel;
    end
  end

  assign mem_req_valid_o = out_valid_q;
  assign mem_req_o       = out_q;

  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_o)
  );

endmodule

// ==== hdl/stride_prefetcher.sv ====
`timescale 1ns/100ps

module stride_prefetcher #(
  parameter int unsigned MaxInflight = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        pf_base_set_i,
  input  logic [63:0]                 pf_base_i,
  output logic [63:0]                 pf_base_o,
  input  logic                        pf_param_set_i,
  input  cache_subsys_pkg::pf_param_u pf_param_i,
  output cache_subsys_pkg::pf_param_u pf_param_o,
  output logic [63:0]                 pf_status_o,
  input  logic                        snoop_valid_i,
  input  cache_subsys_pkg::snoop_t    snoop_i,
  output logic                        pf_req_valid_o,
  input  logic                        pf_req_ready_i,
  output cache_subsys_pkg::rd_req_t   pf_req_o,
  input  logic                        pf_done_i
);

  localparam int unsigned AW   = cache_subsys_pkg::ADDR_WIDTH;
  localparam int unsigned CntW = $clog2(MaxInflight + 1);

  logic [63:0]                 base_q;
  cache_subsys_pkg::pf_param_u param_q;
  logic                        active_q;
  logic [7:0]                  remaining_q;
  logic [AW-1:0]               next_addr_q;
  logic [CntW-1:0]             inflight_q;
  logic [63:0]                 status_q;

  logic signed [AW-1:0] stride_ext;
  logic [AW-1:0]        stride_bytes;
  logic                 trigger;
  logic                 issue;
  logic                 last_issue;

  // Signed line count scaled to a byte offset
  assign stride_ext   = param_q.fields.stride_lines;
  assign stride_bytes = stride_ext * AW'(cache_subsys_pkg::LINE_BYTES);

  assign trigger = snoop_valid_i && param_q.fields.enable && !active_q
                   && (param_q.fields.burst_len != 8'd0)
                   && (snoop_i.addr == base_q[AW-1:0]);

  // Throttle on outstanding prefetches
  assign pf_req_valid_o = active_q && (inflight_q < CntW'(MaxInflight));
  assign pf_req_o.addr  = next_addr_q;

  assign issue      = pf_req_valid_o && pf_req_ready_i;
  assign last_issue = issue && (remaining_q == 8'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q  <= '0;
      param_q <= '0;
    end else begin
      // Software write wins over the end-of-burst advance
      if (pf_base_set_i) begin
        base_q <= pf_base_i;
      end else if (last_issue) begin
        base_q <= 64'(next_addr_q);
      end
      if (pf_param_set_i) begin
        param_q.raw <= pf_param_i.raw;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q    <= 1'b0;
      remaining_q <= '0;
    end else if (trigger) begin
      active_q    <= 1'b1;
      remaining_q <= param_q.fields.burst_len;
    end else if (issue) begin
      active_q    <= !last_issue;
      remaining_q <= remaining_q - 8'd1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (trigger) begin
      next_addr_q <= base_q[AW-1:0] + stride_bytes;
    end else if (issue) begin
      next_addr_q <= next_addr_q + stride_bytes;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= '0;
      status_q   <= '0;
    end else begin
      case ({issue, pf_done_i})
        2'b10:   inflight_q <= inflight_q + CntW'(1);
        2'b01:   inflight_q <= inflight_q - CntW'(1);
        default: inflight_q <= inflight_q;
      endcase
      if (pf_done_i) begin
        status_q <= status_q + 64'd1;
      end
    end
  end

  assign pf_base_o       = base_q;
  assign pf_param_o.raw  = param_q.raw;
  assign pf_status_o     = status_q;

  // Retire pulses come back through the router
  a_inflight_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) inflight_q <= CntW'(MaxInflight)
  );

endmodule

// ==== hdl/cache_subsys_pkg.sv ====
package cache_subsys_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 64;
  // Prefetch addresses step in whole lines
  localparam int unsigned LINE_BYTES = 16;

  typedef enum logic [1:0] {
    SRC_ICACHE   = 2'd0,
    SRC_DCACHE   = 2'd1,
    SRC_PREFETCH = 2'd2
  } mem_src_e;

  // Read request from any of the three sources
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } rd_req_t;

  // Tagged request on the memory channel, 34 bits
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    mem_src_e              src;
  } mem_req_t;

  // Tagged response on the memory channel, 66 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    mem_src_e              src;
  } mem_rsp_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
  } refill_t;

  // Address of an accepted load
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } snoop_t;

  typedef struct packed {
    logic [38:0]        reserved;
    logic               enable;
    logic [7:0]         burst_len;
    logic signed [15:0] stride_lines;
  } pf_param_fields_t;

  // Prefetcher parameter word, raw for access and fields for decode
  typedef union packed {
    logic [63:0]      raw;
    pf_param_fields_t fields;
  } pf_param_u;

endpackage
